/* include/dma_defines.svh */
// DMA engine bus widths, counter widths and control register reset value
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// byte address width on both masters and the control port
`define DMA_ADDR_W 18

// data width of the read and write masters
`define DMA_DATA_W 64

// transfer length counter width
`define DMA_LEN_W 16

// log2 of the FIFO depth
`define DMA_FIFO_AW 5

// byte lane index within one data beat
`define DMA_LANE_W 3

// control register width and reset value, word size selected
`define DMA_CTRL_W 11
`define DMA_CTRL_RESET 11'h004

`endif

/* hw/dma_reg_pkg.sv */
// DMA control port register map, control bit positions and status layout
package dma_reg_pkg;

  // control port register addresses
  typedef enum logic [2:0] {
    REG_STATUS   = 3'd0,
    REG_RADDR    = 3'd1,
    REG_WADDR    = 3'd2,
    REG_LENGTH   = 3'd3,
    REG_CTRL     = 3'd6,
    REG_CTRL_ALT = 3'd7
  } reg_addr_e;

  // bit positions inside the control register
  typedef enum int unsigned {
    CTRL_BYTE  = 0,
    CTRL_HW    = 1,
    CTRL_WORD  = 2,
    CTRL_GO    = 3,
    CTRL_IEN   = 4,
    CTRL_DWORD = 10
  } ctrl_bit_e;

  // bit positions inside the status register
  typedef enum int unsigned {
    STAT_DONE = 0,
    STAT_BUSY = 1,
    STAT_LEN  = 4
  } status_bit_e;

  localparam int STATUS_W = 5;
  typedef logic [STATUS_W-1:0] status_t;

endpackage

/* hw/dma_xfer_pkg.sv */
// DMA transfer size encoding and read master state encoding
package dma_xfer_pkg;

  // the value is also the address step in bytes
  typedef enum logic [3:0] {
    SIZE_BYTE  = 4'd1,
    SIZE_HALF  = 4'd2,
    SIZE_WORD  = 4'd4,
    SIZE_DWORD = 4'd8
  } xfer_size_e;

  typedef enum logic {
    RD_IDLE   = 1'b0,
    RD_ACCESS = 1'b1
  } rd_state_e;

endpackage

/* hw/dma_regs.sv */
// DMA control registers with address and length counters, completion and interrupt
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_regs
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  dma_reg_pkg::reg_addr_e   ctl_address,
  input  logic                     ctl_chipselect,
  input  logic                     ctl_write_n,
  input  logic [`DMA_ADDR_W-1:0]   ctl_writedata,
  input  logic                     inc_read,
  input  logic                     inc_write,
  input  logic                     fifo_empty,
  output logic [`DMA_ADDR_W-1:0]   ctl_readdata,
  output logic                     ctl_irq,
  output logic [`DMA_ADDR_W-1:0]   read_address,
  output logic [`DMA_ADDR_W-1:0]   write_address,
  output dma_xfer_pkg::xfer_size_e xfer_size,
  output logic                     go,
  output logic                     align_load,
  output logic                     read_stop,
  output logic                     flush
);
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;

  localparam int ADDR_W = `DMA_ADDR_W;
  localparam int LEN_W = `DMA_LEN_W;
  localparam int CTRL_W = `DMA_CTRL_W;

  logic [CTRL_W-1:0] control;
  logic [LEN_W-1:0]  rd_len;
  logic [LEN_W-1:0]  wr_len;
  logic [LEN_W-1:0]  step_len;
  logic [LEN_W-1:0]  rd_len_next;
  logic [LEN_W-1:0]  wr_len_next;
  logic [ADDR_W-1:0] step_addr;
  logic              rd_len_zero;
  logic              wr_len_zero;
  logic              rd_len_hit;
  logic              wr_len_hit;
  logic              done_write;
  logic              p1_done_write;
  logic              xfer_end_q;
  logic              done_rise;
  logic              done;
  logic              len_flag;
  logic              busy;
  logic              ctl_wr;
  logic              status_write;
  logic              len_write;
  logic              ctrl_write;
  status_t           status;

  assign ctl_wr = ctl_chipselect & ~ctl_write_n;
  assign status_write = ctl_wr & (ctl_address == REG_STATUS);
  assign len_write = ctl_wr & (ctl_address == REG_LENGTH);
  assign ctrl_write = ctl_wr & ((ctl_address == REG_CTRL) | (ctl_address == REG_CTRL_ALT));

  // widest selected size wins
  always_comb
  begin
    if (control[CTRL_DWORD])
      xfer_size = SIZE_DWORD;
    else if (control[CTRL_WORD])
      xfer_size = SIZE_WORD;
    else if (control[CTRL_HW])
      xfer_size = SIZE_HALF;
    else
      xfer_size = SIZE_BYTE;
  end

  assign step_len = LEN_W'(xfer_size);
  assign step_addr = ADDR_W'(xfer_size);
  assign rd_len_next = rd_len - step_len;
  assign wr_len_next = wr_len - step_len;
  assign rd_len_hit = inc_read & ~rd_len_zero & (rd_len_next == '0);
  assign wr_len_hit = inc_write & ~wr_len_zero & (wr_len_next == '0);

  // a fresh length write starts a new transfer
  assign p1_done_write = ~len_write & (wr_len_hit | wr_len_zero);
  assign read_stop = rd_len_hit | rd_len_zero | done_write;

  assign go = control[CTRL_GO];
  assign align_load = len_write | (ctrl_write & ctl_writedata[CTRL_GO]);
  assign done_rise = go & p1_done_write & ~xfer_end_q;
  assign flush = done_rise;
  assign busy = go & ~(done_write & fifo_empty);
  assign ctl_irq = control[CTRL_IEN] & done;

  always_comb
  begin
    status = '0;
    status[STAT_DONE] = done;
    status[STAT_BUSY] = busy;
    status[STAT_LEN] = len_flag;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      read_address <= '0;
      write_address <= '0;
      control <= `DMA_CTRL_RESET;
      rd_len <= '0;
      wr_len <= '0;
      rd_len_zero <= 1'b1;
      wr_len_zero <= 1'b1;
    end
    else
    begin
      if (ctl_wr & (ctl_address == REG_RADDR))
        read_address <= ctl_writedata;
      else if (inc_read)
        read_address <= read_address + step_addr;
      if (ctl_wr & (ctl_address == REG_WADDR))
        write_address <= ctl_writedata;
      else if (inc_write)
        write_address <= write_address + step_addr;
      if (ctrl_write)
        control <= ctl_writedata[CTRL_W-1:0];
      if (len_write)
      begin
        rd_len <= ctl_writedata[LEN_W-1:0];
        wr_len <= ctl_writedata[LEN_W-1:0];
        rd_len_zero <= 1'b0;
        wr_len_zero <= 1'b0;
      end
      else
      begin
        if (inc_read & ~rd_len_zero)
          rd_len <= rd_len_next;
        if (inc_write & ~wr_len_zero)
          wr_len <= wr_len_next;
        if (rd_len_hit)
          rd_len_zero <= 1'b1;
        if (wr_len_hit)
          wr_len_zero <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      done_write <= 1'b0;
      xfer_end_q <= 1'b0;
      done <= 1'b0;
      len_flag <= 1'b0;
      ctl_readdata <= '0;
    end
    else
    begin
      done_write <= p1_done_write;
      xfer_end_q <= go & p1_done_write;
      // every transfer ends on length
      if (status_write)
      begin
        done <= 1'b0;
        len_flag <= 1'b0;
      end
      else if (done_rise)
      begin
        done <= 1'b1;
        len_flag <= 1'b1;
      end
      case (ctl_address)
        REG_STATUS:             ctl_readdata <= ADDR_W'(status);
        REG_RADDR:              ctl_readdata <= read_address;
        REG_WADDR:              ctl_readdata <= write_address;
        REG_LENGTH:             ctl_readdata <= ADDR_W'(wr_len);
        REG_CTRL, REG_CTRL_ALT: ctl_readdata <= ADDR_W'(control);
        default:                ctl_readdata <= '0;
      endcase
    end
  end

  // software must pick exactly one size before a transfer runs
  a_size_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    go |-> $onehot({control[CTRL_DWORD], control[CTRL_WORD], control[CTRL_HW],
                    control[CTRL_BYTE]}));

endmodule

/* hw/dma_read_master.sv */
// DMA read request FSM with waitrequest hold and FIFO back-pressure
`timescale 1ns/1ps

module dma_read_master
(
  input  logic clk,
  input  logic reset_n,
  input  logic go,
  input  logic read_stop,
  input  logic fifo_full_next,
  input  logic read_waitrequest,
  output logic read_chipselect,
  output logic read_n,
  output logic inc_read
);
  import dma_xfer_pkg::*;

  rd_state_e state;
  rd_state_e state_next;
  logic      can_issue;

  // stop and full already account for the beat accepted this cycle
  assign can_issue = ~read_stop & ~fifo_full_next;

  always_comb
  begin
    state_next = state;
    case (state)
      RD_IDLE:
        if (go & can_issue)
          state_next = RD_ACCESS;
      RD_ACCESS:
        if (~read_waitrequest & ~can_issue)
          state_next = RD_IDLE;
      default:
        state_next = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state <= RD_IDLE;
    else
      state <= state_next;
  end

  assign read_chipselect = (state == RD_ACCESS);
  assign read_n = ~read_chipselect;
  assign inc_read = read_chipselect & ~read_waitrequest;

  // a stalled request stays on the bus
  a_rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
    read_chipselect && read_waitrequest |=> read_chipselect);

endmodule

/* hw/dma_read_align.sv */
// DMA read lane tracker that shifts the addressed slice of each beat to bit 0
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_read_align
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     align_load,
  input  logic [`DMA_ADDR_W-1:0]   read_address,
  input  dma_xfer_pkg::xfer_size_e xfer_size,
  input  logic [`DMA_DATA_W-1:0]   read_readdata,
  input  logic                     read_readdatavalid,
  output logic [`DMA_DATA_W-1:0]   wr_data
);
  import dma_xfer_pkg::*;

  logic [`DMA_LANE_W-1:0] lane;

  // lane follows the returned beats, not the issued addresses
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      lane <= '0;
    else if (align_load)
      lane <= read_address[`DMA_LANE_W-1:0];
    else if (read_readdatavalid)
      lane <= lane + xfer_size[`DMA_LANE_W-1:0];
  end

  always_comb
  begin
    wr_data = read_readdata;
    case (xfer_size)
      SIZE_BYTE:
        wr_data[7:0] = read_readdata[{lane, 3'b000} +: 8];
      SIZE_HALF:
        wr_data[15:0] = read_readdata[{lane[2:1], 4'b0000} +: 16];
      SIZE_WORD:
        wr_data[31:0] = read_readdata[{lane[2], 5'b00000} +: 32];
      default:
        wr_data = read_readdata;
    endcase
  end

endmodule

/* hw/dma_fifo.sv */
// DMA data FIFO with registered read address, collision bypass and projected full
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_fifo
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   wr_en,
  input  logic [`DMA_DATA_W-1:0] wr_data,
  input  logic                   rd_en,
  input  logic                   flush,
  input  logic                   pending_inc,
  output logic [`DMA_DATA_W-1:0] rd_data,
  output logic                   fifo_valid,
  output logic                   fifo_empty,
  output logic                   fifo_full_next
);
  localparam int AW = `DMA_FIFO_AW;
  localparam int DEPTH = 1 << AW;

  logic [`DMA_DATA_W-1:0] mem [DEPTH];
  logic [`DMA_DATA_W-1:0] mem_q;
  logic [`DMA_DATA_W-1:0] bypass_data;
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_addr_q;
  logic [AW-1:0]          rd_addr_next;
  logic [AW:0]            count;
  logic [AW:0]            count_next;
  logic [AW:0]            pending;
  logic [AW:0]            pending_next;
  logic                   collision;
  logic                   bypass_valid;

  assign rd_addr_next = flush ? '0 : (rd_en ? rd_addr_q + 1'b1 : rd_addr_q);
  assign collision = ~flush & wr_en & (wr_ptr == rd_addr_next);

  assign count_next = flush ? '0 : count + (AW+1)'(wr_en) - (AW+1)'(rd_en);

  // stored entries plus reads still in flight
  assign pending_next = flush ? '0 : pending + (AW+1)'(pending_inc) - (AW+1)'(rd_en);
  // top bit set means all DEPTH slots are spoken for
  assign fifo_full_next = pending_next[AW];

  assign fifo_empty = (count == '0);
  assign fifo_valid = ~fifo_empty;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_addr_q <= '0;
      count <= '0;
      pending <= '0;
      bypass_valid <= 1'b0;
    end
    else
    begin
      rd_addr_q <= rd_addr_next;
      count <= count_next;
      pending <= pending_next;
      if (flush)
        wr_ptr <= '0;
      else if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (flush)
        bypass_valid <= 1'b0;
      else if (collision)
        bypass_valid <= 1'b1;
      else if (rd_en)
        bypass_valid <= 1'b0;
    end
  end

  // synchronous RAM read, the old word comes out on a same-slot write
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
    mem_q <= mem[rd_addr_next];
    // a write into the slot being read next lands here too
    if (collision)
      bypass_data <= wr_data;
  end

  assign rd_data = bypass_valid ? bypass_data : mem_q;

  // read back-pressure must keep the FIFO from overrunning
  a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
    wr_en |-> (count < (AW+1)'(DEPTH)));

  a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
    rd_en |-> !fifo_empty);

endmodule

/* hw/dma_write_master.sv */
// DMA write strobe, byte enable decode and write data replication
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_write_master
(
  input  logic                     fifo_valid,
  input  logic [`DMA_DATA_W-1:0]   rd_data,
  input  logic [`DMA_ADDR_W-1:0]   write_address,
  input  dma_xfer_pkg::xfer_size_e xfer_size,
  input  logic                     write_waitrequest,
  output logic                     write_chipselect,
  output logic                     write_n,
  output logic [`DMA_DATA_W/8-1:0] write_byteenable,
  output logic [`DMA_DATA_W-1:0]   write_writedata,
  output logic                     fifo_read
);
  import dma_xfer_pkg::*;

  assign write_chipselect = fifo_valid;
  assign write_n = ~write_chipselect;
  assign fifo_read = write_chipselect & ~write_waitrequest;

  // enables and data stay put until the FIFO head is popped
  always_comb
  begin
    case (xfer_size)
      SIZE_BYTE:
      begin
        write_byteenable = 8'h01 << write_address[2:0];
        write_writedata = {8{rd_data[7:0]}};
      end
      SIZE_HALF:
      begin
        write_byteenable = 8'h03 << {write_address[2:1], 1'b0};
        write_writedata = {4{rd_data[15:0]}};
      end
      SIZE_WORD:
      begin
        write_byteenable = 8'h0f << {write_address[2], 2'b00};
        write_writedata = {2{rd_data[31:0]}};
      end
      default:
      begin
        write_byteenable = 8'hff;
        write_writedata = rd_data;
      end
    endcase
  end

endmodule

/* hw/dma_top.sv */
// DMA engine top level joining registers, read and write masters and the FIFO
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_top
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  dma_reg_pkg::reg_addr_e   ctl_address,
  input  logic                     ctl_chipselect,
  input  logic                     ctl_write_n,
  input  logic [`DMA_ADDR_W-1:0]   ctl_writedata,
  output logic [`DMA_ADDR_W-1:0]   ctl_readdata,
  output logic                     ctl_irq,
  output logic [`DMA_ADDR_W-1:0]   read_address,
  output logic                     read_chipselect,
  output logic                     read_n,
  input  logic [`DMA_DATA_W-1:0]   read_readdata,
  input  logic                     read_readdatavalid,
  input  logic                     read_waitrequest,
  output logic [`DMA_ADDR_W-1:0]   write_address,
  output logic                     write_chipselect,
  output logic                     write_n,
  output logic [`DMA_DATA_W/8-1:0] write_byteenable,
  output logic [`DMA_DATA_W-1:0]   write_writedata,
  input  logic                     write_waitrequest
);
  import dma_xfer_pkg::*;

  xfer_size_e             xfer_size;
  logic                   go;
  logic                   align_load;
  logic                   read_stop;
  logic                   flush;
  logic                   inc_read;
  logic                   fifo_read;
  logic                   fifo_valid;
  logic                   fifo_empty;
  logic                   fifo_full_next;
  logic [`DMA_DATA_W-1:0] fifo_wr_data;
  logic [`DMA_DATA_W-1:0] fifo_rd_data;

  dma_regs u_regs
  (
    .clk            (clk),
    .reset_n        (reset_n),
    .ctl_address    (ctl_address),
    .ctl_chipselect (ctl_chipselect),
    .ctl_write_n    (ctl_write_n),
    .ctl_writedata  (ctl_writedata),
    .inc_read       (inc_read),
    .inc_write      (fifo_read),
    .fifo_empty     (fifo_empty),
    .ctl_readdata   (ctl_readdata),
    .ctl_irq        (ctl_irq),
    .read_address   (read_address),
    .write_address  (write_address),
    .xfer_size      (xfer_size),
    .go             (go),
    .align_load     (align_load),
    .read_stop      (read_stop),
    .flush          (flush)
  );

  dma_read_master u_read_master
  (
    .clk              (clk),
    .reset_n          (reset_n),
    .go               (go),
    .read_stop        (read_stop),
    .fifo_full_next   (fifo_full_next),
    .read_waitrequest (read_waitrequest),
    .read_chipselect  (read_chipselect),
    .read_n           (read_n),
    .inc_read         (inc_read)
  );

  dma_read_align u_read_align
  (
    .clk                (clk),
    .reset_n            (reset_n),
    .align_load         (align_load),
    .read_address       (read_address),
    .xfer_size          (xfer_size),
    .read_readdata      (read_readdata),
    .read_readdatavalid (read_readdatavalid),
    .wr_data            (fifo_wr_data)
  );

  // every returned beat goes straight into the FIFO
  dma_fifo u_fifo
  (
    .clk            (clk),
    .reset_n        (reset_n),
    .wr_en          (read_readdatavalid),
    .wr_data        (fifo_wr_data),
    .rd_en          (fifo_read),
    .flush          (flush),
    .pending_inc    (inc_read),
    .rd_data        (fifo_rd_data),
    .fifo_valid     (fifo_valid),
    .fifo_empty     (fifo_empty),
    .fifo_full_next (fifo_full_next)
  );

  dma_write_master u_write_master
  (
    .fifo_valid        (fifo_valid),
    .rd_data           (fifo_rd_data),
    .write_address     (write_address),
    .xfer_size         (xfer_size),
    .write_waitrequest (write_waitrequest),
    .write_chipselect  (write_chipselect),
    .write_n           (write_n),
    .write_byteenable  (write_byteenable),
    .write_writedata   (write_writedata),
    .fifo_read         (fifo_read)
  );

endmodule

/* testbench/dma_tb.sv */
// DMA engine testbench with source and destination memory models and bus checks
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_tb;
  import dma_reg_pkg::*;

  localparam int AW = `DMA_ADDR_W;
  localparam int MEM_AW = 10;
  localparam int MEM_BYTES = 1 << MEM_AW;
  localparam int TIMEOUT = 4000;

  logic                  clk;
  logic                  reset_n;
  reg_addr_e             ctl_address;
  logic                  ctl_chipselect;
  logic                  ctl_write_n;
  logic [AW-1:0]         ctl_writedata;
  logic [AW-1:0]         ctl_readdata;
  logic                  ctl_irq;
  logic [AW-1:0]         read_address;
  logic                  read_chipselect;
  logic                  read_n;
  logic [63:0]           read_readdata;
  logic                  read_readdatavalid;
  logic                  read_waitrequest;
  logic [AW-1:0]         write_address;
  logic                  write_chipselect;
  logic                  write_n;
  logic [7:0]            write_byteenable;
  logic [63:0]           write_writedata;
  logic                  write_waitrequest;

  logic [7:0]    src_mem [MEM_BYTES];
  logic [7:0]    dst_mem [MEM_BYTES];
  logic [31:0]   lfsr;
  int            cyc;
  int            rd_due [$];
  logic [AW-1:0] rd_addr_q [$];
  logic          back_pressure;
  logic [AW-1:0] rd_base;
  logic [AW-1:0] wr_base;
  int            xfer_bytes;
  int            exp_beats;
  int            wr_beats;
  logic          idle_phase;
  logic          quiet_phase;
  logic          rd_cmp;
  logic [AW-1:0] rd_expect;
  int            bus_errors;
  int            data_errors;
  int            timeouts;

  dma_top DUT
  (
    .clk                (clk),
    .reset_n            (reset_n),
    .ctl_address        (ctl_address),
    .ctl_chipselect     (ctl_chipselect),
    .ctl_write_n        (ctl_write_n),
    .ctl_writedata      (ctl_writedata),
    .ctl_readdata       (ctl_readdata),
    .ctl_irq            (ctl_irq),
    .read_address       (read_address),
    .read_chipselect    (read_chipselect),
    .read_n             (read_n),
    .read_readdata      (read_readdata),
    .read_readdatavalid (read_readdatavalid),
    .read_waitrequest   (read_waitrequest),
    .write_address      (write_address),
    .write_chipselect   (write_chipselect),
    .write_n            (write_n),
    .write_byteenable   (write_byteenable),
    .write_writedata    (write_writedata),
    .write_waitrequest  (write_waitrequest)
  );

  // galois LFSR, one step per random bit
  function automatic logic take_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 29) ^ 8'(a >> 8) ^ 8'h3c;
  endfunction

  // little endian beat around a byte address
  function automatic logic [63:0] beat_data(input logic [AW-1:0] addr);
    logic [63:0] d;
    d = '0;
    for (int j = 0; j < 8; j++)
      d = {src_mem[MEM_AW'(int'({addr[AW-1:3], 3'b000}) + j)], d[63:8]};
    return d;
  endfunction

  // source element for this write offset, repeated over all lanes
  function automatic logic [63:0] expected_wdata(input logic [AW-1:0] waddr);
    logic [63:0] d;
    int          off;
    off = int'(waddr - wr_base);
    d = '0;
    for (int j = 0; j < 8; j++)
      d = {src_mem[MEM_AW'(int'(rd_base) + off + (j % xfer_bytes))], d[63:8]};
    return d;
  endfunction

  function automatic logic [7:0] expected_be(input logic [AW-1:0] waddr);
    logic [7:0] be;
    be = '0;
    for (int j = 0; j < 8; j++)
      be = {(j >= int'(waddr[2:0])) && (j < int'(waddr[2:0]) + xfer_bytes), be[7:1]};
    return be;
  endfunction

  function automatic logic [AW-1:0] size_ctrl(input int size);
    case (size)
      1:       return AW'(1 << CTRL_BYTE);
      2:       return AW'(1 << CTRL_HW);
      4:       return AW'(1 << CTRL_WORD);
      default: return AW'(1 << CTRL_DWORD);
    endcase
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // slave side drive, waitrequest and read returns in order
  initial
  begin
    cyc = 0;
    read_readdata = '0;
    read_readdatavalid = 1'b0;
    read_waitrequest = 1'b0;
    write_waitrequest = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      cyc = cyc + 1;
      read_waitrequest = back_pressure ? take_bit() : 1'b0;
      write_waitrequest = back_pressure ? take_bit() : 1'b0;
      read_readdatavalid = 1'b0;
      if (rd_due.size() > 0 && rd_due[0] <= cyc)
      begin
        read_readdatavalid = 1'b1;
        read_readdata = beat_data(rd_addr_q.pop_front());
        void'(rd_due.pop_front());
      end
    end
  end

  // accepted requests seen half a cycle before the edge
  initial
  begin
    int         lat;
    int         due;
    int         last_due;
    logic [63:0] wd;
    logic [7:0]  be;
    last_due = 0;
    forever
    begin
      @(negedge clk);
      #0.5;
      if (read_chipselect && !read_waitrequest)
      begin
        lat = 1 + int'({take_bit(), take_bit()});
        due = cyc + lat;
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rd_due.push_back(due);
        rd_addr_q.push_back(read_address);
      end
      if (write_chipselect && !write_waitrequest)
      begin
        wd = write_writedata;
        be = write_byteenable;
        for (int j = 0; j < 8; j++)
        begin
          if (be[0])
            dst_mem[MEM_AW'(int'({write_address[AW-1:3], 3'b000}) + j)] = wd[7:0];
          wd = wd >> 8;
          be = be >> 1;
        end
        wr_beats = wr_beats + 1;
      end
    end
  end

  a_idle: assert property (@(negedge clk) idle_phase |->
      !read_chipselect && !write_chipselect && !ctl_irq && read_n && write_n)
    else
    begin
      bus_errors++;
      $display("FAIL %0t read_cs/write_cs/ctl_irq expected 000 actual %b%b%b",
               $time, read_chipselect, write_chipselect, ctl_irq);
    end

  a_quiet: assert property (@(negedge clk) quiet_phase |-> !read_chipselect && !write_chipselect)
    else
    begin
      bus_errors++;
      $display("FAIL %0t read_cs/write_cs expected 00 actual %b%b",
               $time, read_chipselect, write_chipselect);
    end

  a_readback: assert property (@(negedge clk) rd_cmp |-> ctl_readdata == rd_expect)
    else
    begin
      bus_errors++;
      $display("FAIL %0t ctl_readdata expected %h actual %h", $time, rd_expect, ctl_readdata);
    end

  a_wr_be: assert property (@(negedge clk) disable iff (!reset_n)
      write_chipselect |-> write_byteenable == expected_be(write_address))
    else
    begin
      bus_errors++;
      $display("FAIL %0t write_byteenable expected %h actual %h",
               $time, expected_be(write_address), write_byteenable);
    end

  a_wr_data: assert property (@(negedge clk) disable iff (!reset_n)
      write_chipselect |-> write_writedata == expected_wdata(write_address))
    else
    begin
      bus_errors++;
      $display("FAIL %0t write_writedata expected %h actual %h",
               $time, expected_wdata(write_address), write_writedata);
    end

  a_wr_addr: assert property (@(negedge clk) disable iff (!reset_n)
      write_chipselect |-> write_address == wr_base + AW'(wr_beats * xfer_bytes))
    else
    begin
      bus_errors++;
      $display("FAIL %0t write_address expected %h actual %h",
               $time, wr_base + AW'(wr_beats * xfer_bytes), write_address);
    end

  a_irq_last: assert property (@(negedge clk) disable iff (!reset_n)
      $rose(ctl_irq) |-> wr_beats == exp_beats)
    else
    begin
      bus_errors++;
      $display("FAIL %0t write beats at ctl_irq expected %0d actual %0d",
               $time, exp_beats, wr_beats);
    end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [AW-1:0] data);
    ctl_address = addr;
    ctl_writedata = data;
    ctl_chipselect = 1'b1;
    ctl_write_n = 1'b0;
    tick();
    ctl_chipselect = 1'b0;
    ctl_write_n = 1'b1;
  endtask

  // readdata is registered one cycle after the address
  task automatic check_readback(input reg_addr_e addr, input logic [AW-1:0] exp_val);
    ctl_address = addr;
    ctl_chipselect = 1'b1;
    ctl_write_n = 1'b1;
    rd_expect = exp_val;
    tick();
    ctl_chipselect = 1'b0;
    rd_cmp = 1'b1;
    tick();
    rd_cmp = 1'b0;
  endtask

  task automatic check_completion(input logic [AW-1:0] rd, input logic [AW-1:0] wr,
                                  input int len);
    quiet_phase = 1'b1;
    back_pressure = 1'b0;
    check_readback(REG_STATUS, AW'(1 << STAT_DONE) | AW'(1 << STAT_LEN));
    assert (wr_beats == exp_beats)
    else
    begin
      data_errors++;
      $display("FAIL %0t write beat count expected %0d actual %0d", $time, exp_beats, wr_beats);
    end
    for (int i = 0; i < len; i++)
    begin
      assert (dst_mem[MEM_AW'(int'(wr) + i)] == src_mem[MEM_AW'(int'(rd) + i)])
      else
      begin
        data_errors++;
        $display("FAIL %0t dst_mem[%h] expected %h actual %h", $time, int'(wr) + i,
                 src_mem[MEM_AW'(int'(rd) + i)], dst_mem[MEM_AW'(int'(wr) + i)]);
      end
    end
    repeat (4) tick();
    write_reg(REG_STATUS, '0);
    assert (!ctl_irq)
    else
    begin
      data_errors++;
      $display("FAIL %0t ctl_irq expected 0 actual %b", $time, ctl_irq);
    end
    check_readback(REG_STATUS, '0);
  endtask

  task automatic run_copy(input logic [AW-1:0] rd, input logic [AW-1:0] wr, input int len,
                          input int size, input logic bp);
    logic [AW-1:0] size_bits;
    int            n;
    size_bits = size_ctrl(size);
    // go cleared first so the length write does not start reads
    write_reg(REG_CTRL, size_bits);
    write_reg(REG_RADDR, rd);
    write_reg(REG_WADDR, wr);
    write_reg(REG_LENGTH, AW'(len));
    check_readback(REG_RADDR, rd);
    check_readback(REG_WADDR, wr);
    check_readback(REG_LENGTH, AW'(len));
    rd_base = rd;
    wr_base = wr;
    xfer_bytes = size;
    exp_beats = len / size;
    wr_beats = 0;
    for (int i = 0; i < len; i++)
      dst_mem[MEM_AW'(int'(wr) + i)] = ~src_mem[MEM_AW'(int'(rd) + i)];
    back_pressure = bp;
    quiet_phase = 1'b0;
    write_reg(REG_CTRL, size_bits | AW'(1 << CTRL_GO) | AW'(1 << CTRL_IEN));
    n = 0;
    while (!ctl_irq && n < TIMEOUT)
    begin
      tick();
      n++;
    end
    if (!ctl_irq)
    begin
      timeouts++;
      $display("timeout, ctl_irq did not rise within %0d cycles of go", TIMEOUT);
      $display("errors: %0d bus, %0d data, %0d timeout", bus_errors, data_errors, timeouts);
      $display("** FAIL **");
      $finish;
    end
    else
      check_completion(rd, wr, len);
  endtask

  initial
  begin
    reset_n = 1'b0;
    ctl_address = REG_STATUS;
    ctl_chipselect = 1'b0;
    ctl_write_n = 1'b1;
    ctl_writedata = '0;
    lfsr = 32'h849f_3899;
    back_pressure = 1'b0;
    idle_phase = 1'b1;
    quiet_phase = 1'b0;
    rd_cmp = 1'b0;
    rd_expect = '0;
    rd_base = '0;
    wr_base = '0;
    xfer_bytes = 8;
    exp_beats = 0;
    wr_beats = 0;
    bus_errors = 0;
    data_errors = 0;
    timeouts = 0;
    for (int i = 0; i < MEM_BYTES; i++)
    begin
      src_mem[MEM_AW'(i)] = fill_byte(i);
      dst_mem[MEM_AW'(i)] = 8'h00;
    end
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
    tick();
    tick();
    check_readback(REG_CTRL, AW'(`DMA_CTRL_RESET));
    idle_phase = 1'b0;
    quiet_phase = 1'b1;

    run_copy(18'h040, 18'h200, 64, 8, 1'b0);
    run_copy(18'h013, 18'h105, 24, 1, 1'b0);
    run_copy(18'h0a6, 18'h30a, 40, 2, 1'b0);
    run_copy(18'h0c4, 18'h2f0, 48, 4, 1'b0);
    // longer than the FIFO, so projected full throttles reads
    run_copy(18'h104, 18'h30c, 160, 4, 1'b1);
    run_copy(18'h021, 18'h0f6, 70, 1, 1'b1);

    $display("errors: %0d bus, %0d data, %0d timeout", bus_errors, data_errors, timeouts);
    if (bus_errors == 0 && data_errors == 0 && timeouts == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
hw/dma_reg_pkg.sv
hw/dma_xfer_pkg.sv
hw/dma_regs.sv
hw/dma_read_master.sv
hw/dma_read_align.sv
hw/dma_fifo.sv
hw/dma_write_master.sv
hw/dma_top.sv
testbench/dma_tb.sv

/* run.sh */
#!/bin/sh
# build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module dma_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vdma_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1
